// File: hw/dcpIoPkg.sv
package dcpIoPkg;

	// processor port space, 7 bits below address bit 7
	typedef enum logic [6:0]
	{
		afcLo    = 7'd120, // vcxo dac low nibble
		afcHi    = 7'd121, // vcxo dac upper 16 bits, loads the level
		adcPeak  = 7'd122, // adc peak and overflow, read clears
		redOff   = 7'd124,
		redOn    = 7'd125,
		greenOff = 7'd126,
		greenOn  = 7'd127
	} ioPort_e;

	// i/o bus
	localparam int ioAddrBits = 8; // bit 7 set is outside the decoded space
	localparam int ioDataBits = 16;

	// adc front end
	localparam int adcBits  = 14; // offset binary from the converter
	localparam int peakBits = 11; // magnitude of the upper 12 sample bits

	// vcxo trim dac
	localparam int afcDacBits = 20; // level and accumulator
	localparam int afcLoBits  = 4;  // low level bits, from data 15:12

	// frame-start test pin width in mclk cycles
	localparam int stretchCycles = 32;

	// anything without a source reads back as ones
	localparam logic [ioDataBits-1:0] unusedRead = '1;

endpackage

// File: hw/ioDecode.sv
`timescale 1ns/1ps

module ioDecode
(
	input  logic                              mclk,
	input  logic                              rst,
	input  logic [dcpIoPkg::ioAddrBits-1:0]  ioAddr,
	input  logic                              ioWr,
	input  logic                              ioRd,
	input  logic [dcpIoPkg::ioDataBits-1:0]  peakWord, // from the adc front end
	output logic [dcpIoPkg::ioDataBits-1:0]  ioDout,
	output logic                              afcLoWr,
	output logic                              afcHiWr,
	output logic                              peakRd,
	output logic [1:0]                        ledWr,    // bit 0 red, bit 1 green
	output logic                              ledOn
);

	logic       inSpace; // address bit 7 clear
	logic [6:0] port;
	logic [dcpIoPkg::ioAddrBits-1:0] rdSel; // registered read select

	assign inSpace = ~ioAddr[7];
	assign port    = ioAddr[6:0];

	// write strobes, one cycle wide while ioWr is up
	assign afcLoWr = ioWr && inSpace && (port == dcpIoPkg::afcLo);
	assign afcHiWr = ioWr && inSpace && (port == dcpIoPkg::afcHi);

	// led pairs share all but the low bit
	assign ledWr[0] = ioWr && inSpace &&
		((port == dcpIoPkg::redOff) || (port == dcpIoPkg::redOn));
	assign ledWr[1] = ioWr && inSpace &&
		((port == dcpIoPkg::greenOff) || (port == dcpIoPkg::greenOn));
	assign ledOn = ioAddr[0]; // odd port turns on

	// read of the peak port, clears peak and overflow downstream
	assign peakRd = ioRd && inSpace && (port == dcpIoPkg::adcPeak);

	// select captured every cycle, data returned the cycle after
	always_ff @(posedge mclk)
	begin
		if (rst)
			rdSel <= '1; // out of space, reads as unused
		else
			rdSel <= ioAddr;
	end

	// read multiplexer
	always_comb
	begin
		if (rdSel[7])
			ioDout = dcpIoPkg::unusedRead; // undecoded half
		else if (rdSel[6:0] == dcpIoPkg::adcPeak)
			ioDout = peakWord;
		else
			ioDout = dcpIoPkg::unusedRead;
	end

	// one peripheral written per bus cycle
	assert property (@(posedge mclk) disable iff (rst)
		$onehot0({afcLoWr, afcHiWr, ledWr}))
		else $error("ioDecode: more than one write strobe");

endmodule

// File: hw/adcFrontEnd.sv
`timescale 1ns/1ps

module adcFrontEnd
(
	input  logic                             mclk,
	input  logic                             rst,
	input  logic [dcpIoPkg::adcBits-1:0]    adc,      // offset binary
	input  logic                             adcOvf,   // converter overrange
	input  logic                             peakRd,   // port read, clears after
	output logic [dcpIoPkg::ioDataBits-1:0] peakWord
);

	logic [dcpIoPkg::adcBits-1:0]  adcReg;  // raw capture
	logic [dcpIoPkg::adcBits-1:0]  sample;  // two's complement
	logic [11:0]                    top;     // upper 12 bits of sample
	logic [11:0]                    negTop;
	logic [11:0]                    absVal;  // 0..2048
	logic [dcpIoPkg::peakBits-1:0] mag;     // clipped to 2047
	logic [dcpIoPkg::peakBits-1:0] peak;
	logic                           ovfFlag;

	// first stage, straight capture off the pins
	always_ff @(posedge mclk)
	begin
		adcReg <= adc;
	end

	// second stage, flip msb for two's complement
	always_ff @(posedge mclk)
	begin
		sample <= {~adcReg[dcpIoPkg::adcBits-1], adcReg[dcpIoPkg::adcBits-2:0]};
	end

	// magnitude of the 12 msbs
	assign top    = sample[dcpIoPkg::adcBits-1 -: 12];
	assign negTop = ~top + 12'd1;
	assign absVal = top[11] ? negTop : top;

	always_comb
	begin
		if (absVal[11])
			mag = '1; // only -2048 lands here
		else
			mag = absVal[dcpIoPkg::peakBits-1:0];
	end

	// third stage, running maximum
	always_ff @(posedge mclk)
	begin
		if (rst || peakRd)
			peak <= '0; // read restarts the measurement
		else if (mag > peak)
			peak <= mag;
	end

	// sticky overflow, cleared with the peak
	always_ff @(posedge mclk)
	begin
		if (rst || peakRd)
			ovfFlag <= 1'b0;
		else if (adcOvf)
			ovfFlag <= 1'b1;
	end

	assign peakWord = {ovfFlag, 4'b0000, peak}; // read port layout

	// full-scale negative sample must land as 2047 in the peak
	assert property (@(posedge mclk) disable iff (rst)
		(absVal > 12'd2047 && !peakRd) |=> (peak == 11'd2047))
		else $error("adcFrontEnd: peak not clipped at 2047");

endmodule

// File: hw/deltaSigmaDac.sv
`timescale 1ns/1ps

module deltaSigmaDac
(
	input  logic                             mclk,
	input  logic                             rst,
	input  logic [dcpIoPkg::ioDataBits-1:0] ioDin,
	input  logic                             afcLoWr, // port 120
	input  logic                             afcHiWr, // port 121
	output logic                             vcxo     // 1-bit trim output
);

	logic [dcpIoPkg::afcLoBits-1:0]  loNibble; // held until the high write
	logic [dcpIoPkg::afcDacBits-1:0] level;    // active dac level
	logic [dcpIoPkg::afcDacBits-1:0] acc;
	logic [dcpIoPkg::afcDacBits:0]   sum;      // carry in the msb

	// first write keeps data 15:12 only
	always_ff @(posedge mclk)
	begin
		if (rst)
			loNibble <= '0;
		else if (afcLoWr)
			loNibble <= ioDin[dcpIoPkg::ioDataBits-1 -: dcpIoPkg::afcLoBits];
	end

	// second write transfers all 20 bits at once
	always_ff @(posedge mclk)
	begin
		if (rst)
			level <= '0;
		else if (afcHiWr)
			level <= {ioDin, loNibble};
	end

	// first-order modulator
	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge mclk)
	begin
		if (rst)
		begin
			acc  <= '0;
			vcxo <= 1'b0;
		end
		else
		begin
			acc  <= sum[dcpIoPkg::afcDacBits-1:0]; // wrap, keep residue
			vcxo <= sum[dcpIoPkg::afcDacBits];     // overflow is the output bit
		end
	end

	// halves come on separate bus cycles
	assert property (@(posedge mclk) disable iff (rst)
		!(afcLoWr && afcHiWr))
		else $error("deltaSigmaDac: low and high writes together");

endmodule

// File: hw/indicatorDriver.sv
`timescale 1ns/1ps

module indicatorDriver
(
	input  logic       mclk,
	input  logic       rst,
	input  logic [1:0] ledWr,      // bit 0 red, bit 1 green
	input  logic       ledOn,      // value to write
	input  logic       frameStart, // single-cycle strobe
	output logic       redLed,
	output logic       greenLed,
	output logic       testPin     // stretched frameStart
);

	logic [$clog2(dcpIoPkg::stretchCycles + 1)-1:0] stretchCnt;

	// panel leds, off at power up
	always_ff @(posedge mclk)
	begin
		if (rst)
		begin
			redLed   <= 1'b0;
			greenLed <= 1'b0;
		end
		else
		begin
			if (ledWr[0])
				redLed <= ledOn;
			if (ledWr[1])
				greenLed <= ledOn;
		end
	end

	// down-counter, reloaded by every new strobe
	always_ff @(posedge mclk)
	begin
		if (rst)
			stretchCnt <= '0;
		else if (frameStart)
			stretchCnt <= ($bits(stretchCnt))'(dcpIoPkg::stretchCycles);
		else if (stretchCnt != '0)
			stretchCnt <= stretchCnt - 1'b1;
	end

	assign testPin = (stretchCnt != '0); // high while counting

	// full-width pulse after each strobe
	assert property (@(posedge mclk) disable iff (rst)
		frameStart |=> testPin [*dcpIoPkg::stretchCycles])
		else $error("indicatorDriver: test pulse cut short");

	// drops right after the count runs out unless restarted
	assert property (@(posedge mclk) disable iff (rst)
		(stretchCnt == 1 && !frameStart) |=> !testPin)
		else $error("indicatorDriver: test pulse too long");

endmodule

// File: hw/dcpIoHub.sv
`timescale 1ns/1ps

module dcpIoHub
(
	input  logic                             mclk,
	input  logic                             rst,
	input  logic [dcpIoPkg::ioAddrBits-1:0] ioAddr,
	input  logic [dcpIoPkg::ioDataBits-1:0] ioDin,      // processor write data
	input  logic                             ioWr,
	input  logic                             ioRd,
	input  logic [dcpIoPkg::adcBits-1:0]    adc,        // offset binary
	input  logic                             adcOvf,
	input  logic                             frameStart,
	output logic [dcpIoPkg::ioDataBits-1:0] ioDout,     // read-back data
	output logic                             vcxo,
	output logic                             redLed,
	output logic                             greenLed,
	output logic                             testPin
);

	logic                             afcLoWr;
	logic                             afcHiWr;
	logic                             peakRd;
	logic [1:0]                       ledWr;    // red, green
	logic                             ledOn;
	logic [dcpIoPkg::ioDataBits-1:0] peakWord; // overflow and peak to the mux

	// the only block that looks at addresses
	ioDecode i_ioDecode
	(
		.mclk     (mclk),
		.rst      (rst),
		.ioAddr   (ioAddr),
		.ioWr     (ioWr),
		.ioRd     (ioRd),
		.peakWord (peakWord),
		.ioDout   (ioDout),
		.afcLoWr  (afcLoWr),
		.afcHiWr  (afcHiWr),
		.peakRd   (peakRd),
		.ledWr    (ledWr),
		.ledOn    (ledOn)
	);

	adcFrontEnd i_adcFrontEnd
	(
		.mclk     (mclk),
		.rst      (rst),
		.adc      (adc),
		.adcOvf   (adcOvf),
		.peakRd   (peakRd),   // clears after the read
		.peakWord (peakWord)
	);

	// vcxo trim, two-write load
	deltaSigmaDac i_deltaSigmaDac
	(
		.mclk    (mclk),
		.rst     (rst),
		.ioDin   (ioDin),
		.afcLoWr (afcLoWr),
		.afcHiWr (afcHiWr),
		.vcxo    (vcxo)
	);

	indicatorDriver i_indicatorDriver
	(
		.mclk       (mclk),
		.rst        (rst),
		.ledWr      (ledWr),
		.ledOn      (ledOn),
		.frameStart (frameStart),
		.redLed     (redLed),
		.greenLed   (greenLed),
		.testPin    (testPin)
	);

endmodule

// File: tb/clkGen.sv
`timescale 1ns/1ps

module clkGen
(
	output logic mclk,
	output logic rst
);

	localparam time halfPeriod = 10ns; // 20 ns mclk
	localparam int resetCycles = 2;

	initial
	begin
		mclk = 1'b0;
		forever
			#halfPeriod mclk = ~mclk;
	end

	// synchronous reset, released on a rising edge
	initial
	begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge mclk);
		rst <= 1'b0;
	end

endmodule

// File: tb/dcpIoHubTb.sv
`timescale 1ns/1ps

module dcpIoHubTb;

	localparam int testCycles     = 9600;                 // all tests, roughly
	localparam int watchdogCycles = 2 * testCycles + 800; // margin on top

	logic        mclk;
	logic        rst;
	logic [7:0]  ioAddr;
	logic [15:0] ioDin;
	logic        ioWr;
	logic        ioRd;
	logic [13:0] adc;
	logic        adcOvf;
	logic        frameStart;
	logic [15:0] ioDout;
	logic        vcxo;
	logic        redLed;
	logic        greenLed;
	logic        testPin;

	logic [31:0] lfsrState;
	string       testName;
	int          errCount  = 0;
	int          errAtStart;
	int          passCount = 0;
	int          failCount = 0;

	clkGen i_clkGen (.mclk(mclk), .rst(rst));

	dcpIoHub i_dcpIoHub
	(
		.mclk(mclk), .rst(rst), .ioAddr(ioAddr), .ioDin(ioDin), .ioWr(ioWr), .ioRd(ioRd),
		.adc(adc), .adcOvf(adcOvf), .frameStart(frameStart), .ioDout(ioDout), .vcxo(vcxo),
		.redLed(redLed), .greenLed(greenLed), .testPin(testPin)
	);

	// one step of a 32-bit Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// offset-binary sample to clipped magnitude of its upper 12 bits
	function automatic int sampleMagnitude(input logic [13:0] raw);
		int value;
		int mag;
		value = int'(raw) - 8192; // midscale is zero
		value = value >>> 2;      // drop 2 lsbs, keep sign
		mag   = (value < 0) ? -value : value;
		return (mag > 2047) ? 2047 : mag;
	endfunction

	task automatic randomBits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value     = {value[30:0], lfsrState[0]}; // one bit per step
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	task automatic noteFailure(input string what);
		$display("%s: %s", testName, what);
		errCount++;
	endtask

	task automatic checkEqual(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERR %s %s: expected %0h, actual %0h", testName, what, expected, actual);
			errCount++;
		end
	endtask

	task automatic checkNear(input string what, input int expected, input int actual);
		assert ((actual >= expected - 1) && (actual <= expected + 1))
		else
		begin
			$display("ERR %s %s: expected %0d +-1, actual %0d", testName, what, expected, actual);
			errCount++;
		end
	endtask

	task automatic startTest(input string name);
		testName   = name;
		errAtStart = errCount;
	endtask

	task automatic endTest();
		if (errCount == errAtStart)
		begin
			passCount++;
			$display("PASS %s", testName);
		end
		else
		begin
			failCount++;
			$display("FAIL %s, %0d errors", testName, errCount - errAtStart);
		end
	endtask

	// write strobe seen on the second edge
	task automatic ioWrite(input logic [7:0] addr, input logic [15:0] data);
		@(posedge mclk);
		ioAddr <= addr;
		ioDin  <= data;
		ioWr   <= 1'b1;
		@(posedge mclk);
		ioWr <= 1'b0;
	endtask

	// address one cycle ahead, data taken mid-cycle while ioRd is up
	task automatic ioRead(input logic [7:0] addr, output logic [15:0] data);
		@(posedge mclk);
		ioAddr <= addr;
		@(posedge mclk);
		ioRd <= 1'b1;
		@(negedge mclk);
		data = ioDout; // before the read clear
		@(posedge mclk);
		ioRd <= 1'b0;
	endtask

	task automatic checkLeds(input string what, input logic expRed, input logic expGreen);
		@(negedge mclk);
		checkEqual(what, {expRed, expGreen}, {redLed, greenLed});
	endtask

	task automatic dacLoad(input logic [19:0] level);
		ioWrite(8'(dcpIoPkg::afcLo), {level[3:0], 12'h000}); // nibble in 15:12
		ioWrite(8'(dcpIoPkg::afcHi), level[19:4]);
	endtask

	// ones on vcxo, starting once the new level feeds the carry
	task automatic countOnes(input int cycles, output int ones);
		ones = 0;
		@(posedge mclk);
		repeat (cycles)
		begin
			@(negedge mclk);
			ones += vcxo;
		end
	endtask

	task automatic frameStrobe(output logic pinBefore);
		@(posedge mclk);
		frameStart <= 1'b1;
		@(negedge mclk);
		pinBefore = testPin; // level during the strobe cycle
		@(posedge mclk);
		frameStart <= 1'b0;
	endtask

	task automatic measureHigh(output int width);
		width = 0;
		@(negedge mclk);
		while (testPin && width < 100) // bounded
		begin
			width++;
			@(negedge mclk);
		end
	endtask

	// undecoded half always reads ones
	assert property (@(posedge mclk) disable iff (rst)
		ioAddr[7] |=> (ioDout == dcpIoPkg::unusedRead))
		else noteFailure("read of an address with bit 7 set did not return all ones");

	assert property (@(posedge mclk) disable iff (rst)
		(ioWr && ioAddr == 8'(dcpIoPkg::redOn)) |=> redLed)
		else noteFailure("red LED did not turn on after a port 125 write");

	assert property (@(posedge mclk) disable iff (rst)
		(ioWr && ioAddr == 8'(dcpIoPkg::greenOff)) |=> !greenLed)
		else noteFailure("green LED did not turn off after a port 126 write");

	assert property (@(posedge mclk) disable iff (rst)
		$rose(testPin) |-> $past(frameStart))
		else noteFailure("test pin rose without a frame start strobe");

	initial
	begin
		repeat (watchdogCycles) @(posedge mclk);
		$display("watchdog: run did not finish within %0d cycles", watchdogCycles);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] raw;
		logic [15:0] word;
		logic        pinBefore;
		int          expMax;
		int          ones;
		int          width;

		ioAddr     = '0;
		ioDin      = '0;
		ioWr       = 1'b0;
		ioRd       = 1'b0;
		adc        = 14'h2000; // midscale
		adcOvf     = 1'b0;
		frameStart = 1'b0;
		lfsrState  = 32'd32;

		do
			@(posedge mclk);
		while (rst);

		startTest("leds");
		checkLeds("after reset", 1'b0, 1'b0);
		ioWrite(8'd123, '0); // no source there, odd so a stray write would light
		checkLeds("other port", 1'b0, 1'b0);
		ioWrite(8'hFD, '0);  // 125 with bit 7 set
		checkLeds("outside space", 1'b0, 1'b0);
		ioWrite(8'(dcpIoPkg::redOn), '0);
		checkLeds("red on", 1'b1, 1'b0);
		ioWrite(8'(dcpIoPkg::greenOn), '0);
		checkLeds("green on", 1'b1, 1'b1);
		ioWrite(8'(dcpIoPkg::redOff), '0);
		checkLeds("red off", 1'b0, 1'b1);
		ioWrite(8'(dcpIoPkg::greenOff), '0);
		checkLeds("green off", 1'b0, 1'b0);
		endTest();

		startTest("peak");
		ioRead(8'(dcpIoPkg::adcPeak), word); // start from a cleared peak
		expMax = 0;
		repeat (200)
		begin
			randomBits(14, raw);
			@(posedge mclk);
			adc <= raw[13:0];
			if (sampleMagnitude(raw[13:0]) > expMax)
				expMax = sampleMagnitude(raw[13:0]);
		end
		repeat (3)
		begin
			@(posedge mclk);
			adc <= 14'h2000; // flush the pipeline
		end
		ioRead(8'(dcpIoPkg::adcPeak), word);
		checkEqual("first read", expMax, word);
		repeat (4) @(posedge mclk);
		ioRead(8'(dcpIoPkg::adcPeak), word);
		checkEqual("read after clear", 16'h0000, word);
		endTest();

		startTest("overflow");
		@(posedge mclk);
		adcOvf <= 1'b1;
		@(posedge mclk);
		adcOvf <= 1'b0;
		ioRead(8'(dcpIoPkg::adcPeak), word);
		checkEqual("sticky flag", 16'h8000, word);
		ioRead(8'(dcpIoPkg::adcPeak), word);
		checkEqual("flag cleared", 16'h0000, word);
		endTest();

		startTest("vcxoDensity");
		dacLoad(20'h40000);
		countOnes(4096, ones);
		checkNear("quarter level", 1024, ones);
		dacLoad(20'hC0000);
		countOnes(4096, ones);
		checkNear("three quarter level", 3072, ones);
		endTest();

		startTest("twoWriteLoad");
		ioWrite(8'(dcpIoPkg::afcLo), 16'hF000); // low half only, level must hold
		countOnes(1024, ones);
		checkNear("density after low write", 768, ones);
		ioRead(8'd123, word);
		checkEqual("port 123", 16'hFFFF, word);
		ioRead(8'd0, word);
		checkEqual("port 0", 16'hFFFF, word);
		ioRead(8'd119, word);
		checkEqual("port 119", 16'hFFFF, word);
		ioRead(8'hFA, word); // peak port with bit 7 set
		checkEqual("address 0xFA", 16'hFFFF, word);
		ioRead(8'hFF, word);
		checkEqual("address 0xFF", 16'hFFFF, word);
		endTest();

		startTest("stretcher");
		frameStrobe(pinBefore);
		checkEqual("pin during strobe", 1'b0, pinBefore);
		measureHigh(width);
		checkEqual("single pulse width", 32, width);
		frameStrobe(pinBefore);
		repeat (10) @(posedge mclk);
		frameStrobe(pinBefore); // restart mid-stretch
		checkEqual("pin before restart", 1'b1, pinBefore);
		measureHigh(width);
		checkEqual("width after restart", 32, width);
		endTest();

		$display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
		if (failCount == 0 && errCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: dcpIoHub.f
hw/dcpIoPkg.sv
hw/ioDecode.sv
hw/adcFrontEnd.sv
hw/deltaSigmaDac.sv
hw/indicatorDriver.sv
hw/dcpIoHub.sv
tb/clkGen.sv
tb/dcpIoHubTb.sv

// File: Bender.yml
package:
  name: dcpIoHub

sources:
  # package first, then leaf modules, then the top level
  - files:
      - hw/dcpIoPkg.sv
      - hw/ioDecode.sv
      - hw/adcFrontEnd.sv
      - hw/deltaSigmaDac.sv
      - hw/indicatorDriver.sv
      - hw/dcpIoHub.sv

  # testbench, top module dcpIoHubTb
  - target: test
    files:
      - tb/clkGen.sv
      - tb/dcpIoHubTb.sv
